/* filelist.f */
hdl/npc_pkg.sv
hdl/decode_if.sv
hdl/inst_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/npc.sv
tests/npc_properties.sv
tests/npc_tb.sv

/* run.sh */
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module npc_tb -f filelist.f -o npc_sim \
    && ./obj_dir/npc_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/npc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_tb;
    import npc_pkg::*;

    localparam int clk_period = 4;
    localparam int prog_len = 40;
    localparam logic [xlen-1:0] data_base = 32'h8000_1000;

    logic clk;
    logic reset;
    logic [xlen-1:0] inst_addr;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] data_addr;
    logic data_rd_en;
    logic data_wr_en;
    logic [xlen-1:0] data_wdata;
    logic [3:0] data_wmask;
    logic [xlen-1:0] data_rdata;
    logic halt;

    // byte memories, low address byte is the index
    logic [7:0] imem [0:255];
    logic [7:0] dmem [0:255];
    logic [7:0] dmem_init [0:255];
    logic [7:0] iidx;
    logic [7:0] didx;

    // expected stores, in program order
    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];
    logic [3:0] exp_mask [$];
    int exp_test [$];
    int test_errors [5];
    string test_names [5] = '{"reset", "alu", "load_byte", "control", "halt"};
    int store_idx = 0;
    int errors = 0;
    int passed = 0;
    int asm_idx = 0;
    integer seed;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] op_c;
    logic [xlen-1:0] loop_n;
    logic [xlen-1:0] first_word;
    logic [xlen-1:0] prev_addr = '0;
    logic prev_halt = 1'b0;

    npc npc_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .data_addr  (data_addr),
        .data_rd_en (data_rd_en),
        .data_wr_en (data_wr_en),
        .data_wdata (data_wdata),
        .data_wmask (data_wmask),
        .data_rdata (data_rdata),
        .halt       (halt)
    );

    bind npc npc_properties npc_props (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .data_rd_en (data_rd_en),
        .data_wr_en (data_wr_en),
        .data_wmask (data_wmask),
        .halt       (halt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    // combinational little-endian reads
    assign iidx = inst_addr[7:0];
    assign didx = data_addr[7:0];
    assign inst = {imem[iidx + 8'd3], imem[iidx + 8'd2], imem[iidx + 8'd1], imem[iidx]};
    assign data_rdata = {dmem[didx + 8'd3], dmem[didx + 8'd2], dmem[didx + 8'd1], dmem[didx]};

    // byte-masked commit at the rising edge
    always @(posedge clk) begin
        if (data_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wmask[b]) begin
                    dmem[didx + 8'(b)] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] pc_of(input int idx);
        return reset_pc + 32'(4 * idx);
    endfunction

    // instruction formats of the base isa
    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7_base, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // stores always go through x10, the data base
    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd10, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3_bne, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input opcode_e op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    task automatic place_inst(input int idx, input logic [31:0] word);
        for (int b = 0; b < 4; b++) begin
            imem[8'(idx * 4 + b)] = word[8*b +: 8];
        end
    endtask

    task automatic emit(input logic [31:0] word);
        place_inst(asm_idx, word);
        asm_idx++;
    endtask

    task automatic put_word(input int off, input logic [31:0] value);
        for (int b = 0; b < 4; b++) begin
            dmem[8'(off + b)] = value[8*b +: 8];
        end
    endtask

    task automatic expect_store(input int test, input logic [7:0] off,
                                input logic [31:0] value, input logic [3:0] mask);
        exp_addr.push_back(data_base + {24'h0, off});
        exp_data.push_back(value);
        exp_mask.push_back(mask);
        exp_test.push_back(test);
    endtask

    task automatic check_value(input int test, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            test_errors[test]++;
            errors++;
        end
    endtask

    task automatic check_true(input int test, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR time=%0t %s", $time, what);
            test_errors[test]++;
            errors++;
        end
    endtask

    task automatic report_test(input int test);
        if (test_errors[test] == 0) begin
            passed++;
        end
        $display("test %-9s %s, %0d errors", test_names[test],
                 (test_errors[test] == 0) ? "ok" : "failed", test_errors[test]);
    endtask

    // every store must match the next expected one
    always @(negedge clk) begin
        int t;
        if (data_wr_en) begin
            if (halt) begin
                check_true(4, 1'b0, "store issued while halted");
            end else if (store_idx >= exp_addr.size()) begin
                check_true(4, 1'b0, "store issued past the end of the program");
            end else begin
                t = exp_test[store_idx];
                check_value(t, "data_addr", exp_addr[store_idx], data_addr);
                check_value(t, "data_wmask", {28'h0, exp_mask[store_idx]}, {28'h0, data_wmask});
                // byte stores only own lane 0
                if (exp_mask[store_idx] == 4'b0001) begin
                    check_value(t, "data_wdata", {24'h0, exp_data[store_idx][7:0]},
                                {24'h0, data_wdata[7:0]});
                end else begin
                    check_value(t, "data_wdata", exp_data[store_idx], data_wdata);
                end
                store_idx++;
                // the last test is closed by the main sequence
                if (store_idx < exp_addr.size() && exp_test[store_idx] != t) begin
                    report_test(t);
                end
            end
        end
    end

    // fetch sequence after jumps, sb footprint and halt
    always @(negedge clk) begin
        // lbu must enable the read of the random word
        if (inst_addr == pc_of(20)) begin
            check_value(2, "data_rd_en", 32'd1, {31'd0, data_rd_en});
            check_value(2, "data_addr", data_base + 32'd8, data_addr);
        end
        if (prev_addr == pc_of(19)) begin
            check_value(2, "dmem[0x64]", {24'h0, op_b[7:0]}, {24'h0, dmem[8'h64]});
            for (int k = 8'h65; k < 8'h68; k++) begin
                check_value(2, "dmem[0x65..0x67]", {24'h0, dmem_init[k]}, {24'h0, dmem[k]});
            end
        end
        if (prev_addr == pc_of(27)) begin
            check_value(3, "inst_addr", pc_of(28), inst_addr);
        end
        if (prev_addr == pc_of(29)) begin
            check_value(3, "inst_addr", pc_of(32), inst_addr);
        end
        if (prev_addr == pc_of(34)) begin
            check_value(3, "inst_addr", pc_of(37), inst_addr);
        end
        if (prev_addr == pc_of(38) && !prev_halt) begin
            check_value(4, "halt", 32'd1, {31'd0, halt});
        end
        if (halt === 1'b1) begin
            check_value(4, "inst_addr", pc_of(38), inst_addr);
        end
        prev_addr = inst_addr;
        prev_halt = (halt === 1'b1);
    end

    initial begin
        reset = 1'b1;
        seed = 32'h7b321493;
        op_a = $random(seed);
        op_b = $random(seed);
        op_c = $random(seed);
        loop_n = ($random(seed) & 32'd7) + 32'd1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 8'h00;
            dmem[i] = 8'(i * 37 + 11);
        end
        put_word(0, op_a);
        put_word(4, op_b);
        put_word(8, op_c);
        put_word(12, loop_n);
        for (int i = 0; i < 256; i++) begin
            dmem_init[i] = dmem[i];
        end

        // x10 = data base, x1/x2 = operands
        emit(enc_u(op_lui, 10, 20'h80001));
        emit(enc_i(op_load, f3_word, 1, 10, 12'h000));
        emit(enc_i(op_load, f3_word, 2, 10, 12'h004));
        emit(enc_r(f3_add, 3, 1, 2));
        emit(enc_s(f3_word, 3, 12'h040));
        expect_store(1, 8'h40, op_a + op_b, 4'b1111);
        emit(enc_i(op_imm, f3_add, 4, 1, 12'hffb));
        emit(enc_s(f3_word, 4, 12'h044));
        expect_store(1, 8'h44, op_a - 32'd5, 4'b1111);
        emit(enc_r(f3_xor, 5, 1, 2));
        emit(enc_s(f3_word, 5, 12'h048));
        expect_store(1, 8'h48, op_a ^ op_b, 4'b1111);
        emit(enc_r(f3_or, 6, 1, 2));
        emit(enc_s(f3_word, 6, 12'h04c));
        expect_store(1, 8'h4c, op_a | op_b, 4'b1111);
        emit(enc_r(f3_sltu, 7, 1, 2));
        emit(enc_s(f3_word, 7, 12'h050));
        expect_store(1, 8'h50, (op_a < op_b) ? 32'd1 : 32'd0, 4'b1111);
        // immediate 0x800 sign-extends to 0xfffff800
        emit(enc_i(op_imm, f3_sltu, 8, 1, 12'h800));
        emit(enc_s(f3_word, 8, 12'h054));
        expect_store(1, 8'h54, (op_a < 32'hffff_f800) ? 32'd1 : 32'd0, 4'b1111);
        emit(enc_u(op_lui, 9, 20'h12345));
        emit(enc_s(f3_word, 9, 12'h058));
        expect_store(1, 8'h58, 32'h1234_5000, 4'b1111);
        emit(enc_u(op_auipc, 9, 20'h00010));
        emit(enc_s(f3_word, 9, 12'h05c));
        expect_store(1, 8'h5c, pc_of(17) + 32'h0001_0000, 4'b1111);

        // byte store, then lbu of a random word
        emit(enc_s(f3_sb, 2, 12'h064));
        expect_store(2, 8'h64, {24'h0, op_b[7:0]}, 4'b0001);
        emit(enc_i(op_load, f3_lbu, 11, 10, 12'h008));
        emit(enc_s(f3_word, 11, 12'h060));
        expect_store(2, 8'h60, {24'h0, op_c[7:0]}, 4'b1111);

        // counted loop on x13 up to x12
        emit(enc_i(op_load, f3_word, 12, 10, 12'h00c));
        emit(enc_i(op_imm, f3_add, 13, 0, 12'h000));
        emit(enc_i(op_imm, f3_add, 13, 13, 12'h001));
        emit(enc_bne(13, 12, 13'h1ffc));
        emit(enc_s(f3_word, 13, 12'h068));
        expect_store(3, 8'h68, loop_n, 4'b1111);
        // never taken, target would skip the store
        emit(enc_bne(13, 13, 13'h008));
        emit(enc_s(f3_word, 12, 12'h06c));
        expect_store(3, 8'h6c, loop_n, 4'b1111);
        emit(enc_jal(15, 21'h00c));
        emit(enc_s(f3_word, 0, 12'h070));
        emit(enc_s(f3_word, 0, 12'h070));
        emit(enc_s(f3_word, 15, 12'h070));
        expect_store(3, 8'h70, pc_of(29) + 32'd4, 4'b1111);
        emit(enc_u(op_auipc, 16, 20'h00000));
        emit(enc_i(op_jalr, f3_jalr, 17, 16, 12'h010));
        emit(enc_s(f3_word, 0, 12'h074));
        emit(enc_s(f3_word, 0, 12'h074));
        emit(enc_s(f3_word, 17, 12'h074));
        expect_store(3, 8'h74, pc_of(34) + 32'd4, 4'b1111);
        emit(ebreak_inst);
        // must never execute
        emit(enc_s(f3_word, 0, 12'h078));

        // a store, then a load, then a store sit at the reset address
        first_word = {imem[3], imem[2], imem[1], imem[0]};
        for (int i = 0; i < 3; i++) begin
            if (i == 1) begin
                place_inst(0, enc_i(op_load, f3_word, 1, 10, 12'h000));
            end else begin
                place_inst(0, enc_s(f3_word, 1, 12'h000));
            end
            @(negedge clk);
            check_value(0, "inst_addr", reset_pc, inst_addr);
            check_value(0, "data_wr_en", 32'd0, {31'd0, data_wr_en});
            check_value(0, "data_rd_en", 32'd0, {31'd0, data_rd_en});
            check_value(0, "halt", 32'd0, {31'd0, halt});
        end
        place_inst(0, first_word);
        reset = 1'b0;
        check_value(0, "inst_addr", reset_pc, inst_addr);
        report_test(0);

        while (halt !== 1'b1) begin
            @(negedge clk);
        end
        // stay halted for a while, no stores expected
        repeat (8) begin
            @(negedge clk);
        end
        report_test(3);
        check_true(4, store_idx == exp_addr.size(), "not every expected store was seen");
        report_test(4);
        errors += npc_inst.npc_props.failures;
        $display("summary: %0d tests ok, %0d tests failed, %0d errors", passed,
                 5 - passed, errors);
        if (errors == 0 && passed == 5) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // four cycles per program instruction plus reset
    initial begin
        #((prog_len * 4 + 3) * clk_period);
        $display("ERROR timeout, halt not reached within %0d cycles", prog_len * 4);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/npc_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_properties (
    input wire clk,
    input wire reset,
    input wire [npc_pkg::xlen-1:0] inst_addr,
    input wire data_rd_en,
    input wire data_wr_en,
    input wire [3:0] data_wmask,
    input wire halt
);

    // failed property count
    int failures = 0;

    // halt only clears through reset
    halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
        else begin
            $error("halt dropped without reset");
            failures++;
        end

    // pc frozen once halted
    halt_pc_stable: assert property (@(posedge clk) disable iff (reset)
        halt |=> $stable(inst_addr))
        else begin
            $error("inst_addr moved while halted");
            failures++;
        end

    enables_exclusive: assert property (@(posedge clk) !(data_rd_en && data_wr_en))
        else begin
            $error("data read and write enables both high");
            failures++;
        end

    // sw or sb only
    store_mask_legal: assert property (@(posedge clk)
        data_wr_en |-> (data_wmask == 4'b0001 || data_wmask == 4'b1111))
        else begin
            $error("illegal store byte mask");
            failures++;
        end

endmodule

`default_nettype wire

/* hdl/npc.sv */
`timescale 1ns/10ps
`default_nettype none

module npc (
    input wire clk,
    input wire reset,
    output logic [npc_pkg::xlen-1:0] inst_addr,
    input wire [npc_pkg::xlen-1:0] inst,
    output logic [npc_pkg::xlen-1:0] data_addr,
    output logic data_rd_en,
    output logic data_wr_en,
    output logic [npc_pkg::xlen-1:0] data_wdata,
    output logic [3:0] data_wmask,
    input wire [npc_pkg::xlen-1:0] data_rdata,
    output logic halt
);
    import npc_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] pc_plus4;
    logic halt_q;
    logic active;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] eff_addr;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;
    logic jump;
    logic taken;

    decode_if dec ();

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    // nothing commits in reset or after ebreak
    assign active = ~reset & ~halt_q;

    register_file u_regfile (
        .clk    (clk),
        .wen    (dec.reg_wen & active),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // operand muxes, pc only for auipc
    assign alu_src1 = dec.src1_is_pc ? pc : rs1_data;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rs2_data;

    alu u_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    // jal and jalr are the only pc+4 writers
    assign jump     = (dec.wb_sel == wb_pc4);
    assign taken    = dec.is_branch & alu_result[0];
    assign pc_plus4 = pc + 32'd4;
    // shared by loads, stores and the jalr target
    assign eff_addr = rs1_data + dec.imm;

    always_comb begin
        if (dec.is_ebreak || halt_q) begin
            next_pc = pc;
        end else if (dec.is_jalr) begin
            next_pc = {eff_addr[xlen-1:1], 1'b0};
        end else if (jump || taken) begin
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            halt_q <= 1'b0;
        end else begin
            pc <= next_pc;
            // sticky until reset
            if (dec.is_ebreak) begin
                halt_q <= 1'b1;
            end
        end
    end

    assign inst_addr = pc;
    assign halt      = halt_q;

    // data port
    assign data_addr  = eff_addr;
    assign data_rd_en = dec.is_load & active;
    assign data_wr_en = dec.is_store & active;
    // sb keeps rs2 low byte in lane 0
    assign data_wdata = dec.is_byte ? {24'h000000, rs2_data[7:0]} : rs2_data;
    assign data_wmask = !dec.is_store ? 4'b0000 : (dec.is_byte ? 4'b0001 : 4'b1111);

    // lbu zero-extends the low byte
    assign load_data = dec.is_byte ? {24'h000000, data_rdata[7:0]} : data_rdata;

    always_comb begin
        case (dec.wb_sel)
            wb_alu:  wb_data = alu_result;
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = pc_plus4;
            wb_imm:  wb_data = dec.imm;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input wire [npc_pkg::xlen-1:0] src1,
    input wire [npc_pkg::xlen-1:0] src2,
    input var npc_pkg::alu_op_e op,
    output logic [npc_pkg::xlen-1:0] result
);
    import npc_pkg::*;

    logic [xlen-1:0] sum;
    logic lt_u;
    logic ne;

    assign sum  = src1 + src2;
    // unsigned compare for sltu/sltiu
    assign lt_u = (src1 < src2);
    // bne decision
    assign ne   = (src1 != src2);

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
            alu_ne:   result = {{(xlen-1){1'b0}}, ne};
            alu_xor:  result = src1 ^ src2;
            alu_or:   result = src1 | src2;
            default:  result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input wire clk,
    input wire wen,
    input wire [npc_pkg::reg_idx_w-1:0] waddr,
    input wire [npc_pkg::xlen-1:0] wdata,
    input wire [npc_pkg::reg_idx_w-1:0] raddr1,
    input wire [npc_pkg::reg_idx_w-1:0] raddr2,
    output logic [npc_pkg::xlen-1:0] rdata1,
    output logic [npc_pkg::xlen-1:0] rdata2
);
    import npc_pkg::*;

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        // writes to x0 are dropped
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input wire [npc_pkg::xlen-1:0] inst,
    decode_if.decoder dec
);
    import npc_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // fixed field positions
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.rd  = inst[11:7];

    // all formats sign-extend from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // safe defaults, unknown encodings fall through as a nop
        dec.imm         = '0;
        dec.alu_op      = alu_add;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        dec.reg_wen     = 1'b0;
        dec.wb_sel      = wb_alu;
        dec.is_load     = 1'b0;
        dec.is_store    = 1'b0;
        dec.is_byte     = 1'b0;
        dec.is_branch   = 1'b0;
        dec.is_jalr     = 1'b0;
        dec.is_ebreak   = 1'b0;
        case (opcode)
            op_lui: begin
                dec.imm     = imm_u;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = wb_imm;
            end
            op_auipc: begin
                // pc + upper immediate through the adder
                dec.imm         = imm_u;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen     = 1'b1;
            end
            op_jal: begin
                dec.imm     = imm_j;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = wb_pc4;
            end
            op_jalr: begin
                dec.imm = imm_i;
                if (funct3 == f3_jalr) begin
                    dec.is_jalr = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.wb_sel  = wb_pc4;
                end
            end
            op_branch: begin
                // only bne, decided by the alu compare
                dec.imm = imm_b;
                if (funct3 == f3_bne) begin
                    dec.is_branch = 1'b1;
                    dec.alu_op    = alu_ne;
                end
            end
            op_load: begin
                dec.imm = imm_i;
                if (funct3 == f3_word || funct3 == f3_lbu) begin
                    dec.is_load = 1'b1;
                    dec.is_byte = (funct3 == f3_lbu);
                    dec.reg_wen = 1'b1;
                    dec.wb_sel  = wb_mem;
                end
            end
            op_store: begin
                dec.imm = imm_s;
                if (funct3 == f3_word || funct3 == f3_sb) begin
                    dec.is_store = 1'b1;
                    dec.is_byte  = (funct3 == f3_sb);
                end
            end
            op_imm: begin
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                // addi and sltiu
                if (funct3 == f3_add) begin
                    dec.reg_wen = 1'b1;
                end else if (funct3 == f3_sltu) begin
                    dec.alu_op  = alu_sltu;
                    dec.reg_wen = 1'b1;
                end
            end
            op_reg: begin
                if (funct7 == f7_base) begin
                    dec.reg_wen = 1'b1;
                    case (funct3)
                        f3_add:  dec.alu_op = alu_add;
                        f3_sltu: dec.alu_op = alu_sltu;
                        f3_xor:  dec.alu_op = alu_xor;
                        f3_or:   dec.alu_op = alu_or;
                        default: dec.reg_wen = 1'b0;
                    endcase
                end
            end
            op_system: begin
                dec.is_ebreak = (inst == ebreak_inst);
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decode_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface decode_if;
    import npc_pkg::*;

    // register indices
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    // sign-extended immediate of the current format
    logic [xlen-1:0] imm;
    // alu control and operand muxes
    alu_op_e alu_op;
    logic src1_is_pc;
    logic src2_is_imm;
    // write-back
    logic reg_wen;
    wb_sel_e wb_sel;
    // memory and flow flags
    logic is_load;
    logic is_store;
    logic is_byte;
    logic is_branch;
    logic is_jalr;
    logic is_ebreak;

    modport decoder (
        output rs1, rs2, rd, imm, alu_op, src1_is_pc, src2_is_imm, reg_wen, wb_sel,
        output is_load, is_store, is_byte, is_branch, is_jalr, is_ebreak
    );

    modport datapath (
        input rs1, rs2, rd, imm, alu_op, src1_is_pc, src2_is_imm, reg_wen, wb_sel,
        input is_load, is_store, is_byte, is_branch, is_jalr, is_ebreak
    );

endinterface

`default_nettype wire

/* hdl/npc_pkg.sv */
`default_nettype none

package npc_pkg;

    // datapath width and register index width
    localparam int xlen = 32;
    localparam int reg_idx_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // ebreak is matched on the full word
    localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    // funct3 codes, grouped by opcode
    localparam logic [2:0] f3_jalr = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_lbu  = 3'b100;
    localparam logic [2:0] f3_sb   = 3'b000;
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;

    // funct7 of the plain register ops (no sub/sra)
    localparam logic [6:0] f7_base = 7'b0000000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sltu,
        alu_ne,
        alu_xor,
        alu_or
    } alu_op_e;

    // source of the rd write-back value
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

endpackage

`default_nettype wire
